//--- uart_cmd_bridge.f
logic/uart_cmd_pkg.sv
logic/cmd_sequencer.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/uart_cmd_bridge.sv
tests/uart_cmd_bridge_checker.sv
tests/uart_cmd_bridge_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing \
  -f uart_cmd_bridge.f \
  --top-module uart_cmd_bridge_tb \
  -Mdir obj_dir -o sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build returned status $status"
  exit 1
fi

output=$(./obj_dir/sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation returned status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi
exit 1

//--- tests/uart_cmd_bridge_tb.sv
module uart_cmd_bridge_tb
  import uart_cmd_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_CMDS        = 40;
  localparam int FRAME_CYCLES    = 11 * BIT_CYCLES;
  localparam int CMD_LIMIT       = 3 * FRAME_CYCLES + GAP_CYCLES + RESP_TIMEOUT_CYCLES;
  localparam longint WATCHDOG_NS = longint'(2 * NUM_CMDS * CMD_LIMIT * 40);
  localparam int RESP_OK         = 0;
  localparam int RESP_BAD_PARITY = 1;
  localparam int RESP_LOW_STOP   = 2;
  localparam int RESP_SILENT     = 3;
  localparam int RESP_GLITCH     = 4;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [CMD_WIDTH-1:0]  cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  logic                  rx;
  logic                  tx;
  logic [BYTE_WIDTH-1:0] read_data;
  logic                  read_rdy;
  logic                  read_err;

  logic [31:0]           lfsr_state = 32'h4828;
  logic [BYTE_WIDTH-1:0] tx_frames[$];
  int                    cycle_cnt = 0;
  int                    frame_end_cycle = 0;
  int                    resp_kind;
  int                    resp_delay;
  int                    glitch_len;
  logic [BYTE_WIDTH-1:0] resp_byte;
  logic                  resp_busy;

  uart_cmd_bridge uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
    cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1.
  endfunction

  function automatic logic [31:0] draw_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
      fail_run($sformatf("error: %s is %h, expected %h", name, got, exp));
  endtask

  task automatic wait_cycle(inout int waited, input string what);
    waited++;
    if (waited > CMD_LIMIT)
      fail_run($sformatf("the bridge never finished the %s command", what));
    @(negedge clk);
  endtask

  task automatic send_frame(input logic [7:0] data, input logic flip_parity, input logic stop_bit);
    int i;
    rx = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (i = 0; i < BYTE_WIDTH; i++)
    begin
      rx = data[i];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    rx = (~^data) ^ flip_parity; // odd parity unless the response is meant to be corrupt.
    repeat (BIT_CYCLES) @(negedge clk);
    rx = stop_bit;
    repeat (BIT_CYCLES) @(negedge clk);
    rx = 1'b1;
  endtask

  task automatic send_response();
    resp_busy = 1'b1;
    repeat (resp_delay + 1) @(negedge clk);
    case (resp_kind)
      RESP_BAD_PARITY: send_frame(resp_byte, 1'b1, 1'b1);
      RESP_LOW_STOP:   send_frame(resp_byte, 1'b0, 1'b0);
      RESP_SILENT:     ;
      RESP_GLITCH:
      begin
        rx = 1'b0;
        repeat (glitch_len) @(negedge clk);
        rx = 1'b1;
        repeat (BIT_CYCLES) @(negedge clk);
        send_frame(resp_byte, 1'b0, 1'b1);
      end
      default:         send_frame(resp_byte, 1'b0, 1'b1);
    endcase
    resp_busy = 1'b0;
  endtask

  // the serial device decodes every tx frame by bit timing and answers reads on rx.
  initial
  begin : device_model
    int                    idle;
    int                    i;
    logic [BYTE_WIDTH-1:0] b;
    logic                  par;
    logic                  stp;
    logic                  expect_lo;
    rx        = 1'b1;
    resp_busy = 1'b0;
    expect_lo = 1'b0;
    idle      = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge clk);
      if (tx !== 1'b0)
        idle++;
      else
      begin
        if (expect_lo)
          assert (idle >= GAP_CYCLES + BIT_CYCLES - HALF_BIT_CYCLES - 2)
          else
            fail_run($sformatf("write frames only %0d idle cycles apart", idle));
        repeat (HALF_BIT_CYCLES - 1) @(negedge clk);
        check_value("tx start bit", 32'(tx), 32'h0);
        for (i = 0; i < BYTE_WIDTH; i++)
        begin
          repeat (BIT_CYCLES) @(negedge clk);
          b[i] = tx;
        end
        repeat (BIT_CYCLES) @(negedge clk);
        par = tx;
        repeat (BIT_CYCLES) @(negedge clk);
        stp = tx;
        check_value("tx parity ones", 32'(^{b, par}), 32'h1);
        check_value("tx stop bit", 32'(stp), 32'h1);
        tx_frames.push_back(b);
        frame_end_cycle = cycle_cnt;
        idle = 0;
        if (expect_lo)
          expect_lo = 1'b0;
        else if (cmd_op_t'(b[7]) == OP_WRITE)
          expect_lo = 1'b1;
        else
          fork
            send_response();
          join_none
      end
    end
  end

  task automatic run_command(input logic [CMD_WIDTH-1:0] cmd, input logic poke);
    int                    waited;
    logic [BYTE_WIDTH-1:0] got;
    waited = 0;
    while (!cmd_rdy)
      @(negedge clk);
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_value("cmd_rdy", 32'(cmd_rdy), 32'h0);
    if (poke)
    begin
      cmd_in  = ~cmd; // must be ignored while busy.
      cmd_vld = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
    end
    if (cmd_op_t'(cmd[15]) == OP_WRITE)
    begin
      while (!cmd_rdy)
      begin
        check_value("read_rdy", 32'(read_rdy), 32'h0);
        wait_cycle(waited, "write");
      end
      check_value("tx frame count", 32'(tx_frames.size()), 32'h2);
      got = tx_frames.pop_front();
      check_value("tx high byte", 32'(got), 32'(cmd[15:8]));
      got = tx_frames.pop_front();
      check_value("tx low byte", 32'(got), 32'(cmd[7:0]));
    end
    else
    begin
      while (!read_rdy)
        wait_cycle(waited, "read");
      check_value("cmd_rdy", 32'(cmd_rdy), 32'h1);
      check_value("tx frame count", 32'(tx_frames.size()), 32'h1);
      got = tx_frames.pop_front();
      check_value("tx high byte", 32'(got), 32'(cmd[15:8]));
      if (resp_kind == RESP_OK || resp_kind == RESP_GLITCH)
      begin
        check_value("read_data", 32'(read_data), 32'(resp_byte));
        check_value("read_err", 32'(read_err), 32'h0);
      end
      else
        check_value("read_err", 32'(read_err), 32'h1);
      if (resp_kind == RESP_SILENT)
      begin
        check_value("read_data", 32'(read_data), 32'h0);
        assert (cycle_cnt - frame_end_cycle <= RESP_TIMEOUT_CYCLES + BIT_CYCLES)
        else
          fail_run("the response timeout took longer than allowed");
      end
      @(negedge clk);
      check_value("read_rdy", 32'(read_rdy), 32'h0);
      while (resp_busy)
        @(negedge clk);
    end
  endtask

  initial
  begin : watchdog
    #(WATCHDOG_NS);
    fail_run("watchdog expired before all commands completed");
  end

  initial
  begin : stimulus
    logic [31:0]          r;
    logic [CMD_WIDTH-1:0] cmd;
    logic                 poke;
    int                   n;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("cmd_rdy", 32'(cmd_rdy), 32'h1);
    check_value("tx", 32'(tx), 32'h1);
    check_value("read_rdy", 32'(read_rdy), 32'h0);
    for (n = 0; n < NUM_CMDS; n++)
    begin
      r = draw_bits(16);
      cmd = r[15:0];
      r = draw_bits(8);
      resp_byte = r[7:0];
      r = draw_bits(3);
      resp_kind = (r[2:0] < 3'd5) ? int'(r[2:0]) : RESP_OK;
      r = draw_bits(10);
      resp_delay = int'(r[9:0]);
      r = draw_bits(7);
      glitch_len = 8 + int'(r[6:0]); // always under half a bit.
      r = draw_bits(1);
      poke = r[0] || (n == 0);
      if (n < 5)
      begin
        cmd[15]   = 1'b0; // first reads walk through every response kind.
        resp_kind = n;
      end
      else if (n == 5)
        cmd[15] = 1'b1;
      run_command(cmd, poke);
    end
    repeat (FRAME_CYCLES + BIT_CYCLES) @(negedge clk);
    check_value("extra tx frames", 32'(tx_frames.size()), 32'h0);
    $display("test passed");
    $finish;
  end

endmodule

//--- tests/uart_cmd_bridge_checker.sv
module uart_cmd_bridge_checker
  import uart_cmd_pkg::*;
(
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cmd_rdy,
  input logic                  tx,
  input logic                  tx_start,
  input logic                  rx_strobe,
  input logic [BYTE_WIDTH-1:0] read_data,
  input logic                  read_rdy,
  input logic                  read_err
);
  timeunit 1ns;
  timeprecision 1ps;

  read_rdy_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  )
  else
    $error("read_rdy stayed high for more than one cycle");

  tx_start_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |=> !tx_start
  )
  else
    $error("tx_start stayed high for more than one cycle");

  // the line must be idle whenever a new command can be taken.
  idle_line: assert property (
    @(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx
  )
  else
    $error("cmd_rdy is high while tx is low");

  no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(read_rdy && tx_start)
  )
  else
    $error("read_rdy and tx_start are high together");

  // a result without a preceding strobe is a timeout.
  timeout_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    (read_rdy && read_err && !$past(rx_strobe)) |-> (read_data == '0)
  )
  else
    $error("timeout result carries nonzero read_data");

endmodule

bind uart_cmd_bridge uart_cmd_bridge_checker u_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .cmd_rdy   (cmd_rdy),
  .tx        (tx),
  .tx_start  (tx_start),
  .rx_strobe (rx_strobe),
  .read_data (read_data),
  .read_rdy  (read_rdy),
  .read_err  (read_err)
);

//--- logic/uart_cmd_bridge.sv
module uart_cmd_bridge
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  input  logic                  rx,
  output logic                  tx,
  output logic [BYTE_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  logic [BYTE_WIDTH-1:0] tx_byte;
  logic                  tx_start;
  logic                  tx_done;
  logic [BYTE_WIDTH-1:0] rx_byte;
  logic                  rx_strobe;
  logic                  rx_err;

  cmd_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_byte   (tx_byte),
    .tx_start  (tx_start),
    .tx_done   (tx_done),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .rx_err    (rx_err),
    .read_data (read_data),
    .read_rdy  (read_rdy),
    .read_err  (read_err)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_byte   (rx_byte),
    .rx_strobe (rx_strobe),
    .rx_err    (rx_err)
  );

endmodule

//--- logic/uart_rx_frame.sv
module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rx,
  output logic [BYTE_WIDTH-1:0] rx_byte,
  output logic                  rx_strobe,
  output logic                  rx_err
);

  logic                  rx_meta;
  logic                  rx_sync;
  logic                  rx_prev;
  logic                  fall;
  frame_phase_t          phase;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic [BYTE_WIDTH-1:0] data_sh;
  logic                  parity_bit;
  logic                  half_end;
  logic                  bit_end;
  logic                  restart;

  assign fall     = rx_prev && !rx_sync;
  assign half_end = (baud_cnt == BAUD_CNT_W'(HALF_BIT_CYCLES - 1));
  assign bit_end  = (baud_cnt == BAUD_CNT_W'(BIT_CYCLES - 1));
  // from mid start on, every bit is sampled one full bit time later.
  assign restart  = (phase == PH_IDLE) || bit_end || (phase == PH_START && half_end);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase     <= PH_IDLE;
      baud_cnt  <= '0;
      bit_idx   <= '0;
      rx_strobe <= 1'b0;
    end
    else
    begin
      rx_strobe <= 1'b0;
      if (restart)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + BAUD_CNT_W'(1);

      case (phase)
        PH_IDLE:
        begin
          if (fall)
            phase <= PH_START;
        end
        PH_START:
        begin
          if (rx_sync)
            phase <= PH_IDLE; // line went back high, so this was a glitch.
          else if (half_end)
          begin
            phase   <= PH_DATA;
            bit_idx <= '0;
          end
        end
        PH_DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == BIT_IDX_W'(BYTE_WIDTH - 1))
              phase <= PH_PARITY;
            else
              bit_idx <= bit_idx + BIT_IDX_W'(1);
          end
        end
        PH_PARITY:
        begin
          if (bit_end)
            phase <= PH_STOP;
        end
        PH_STOP:
        begin
          if (bit_end)
          begin
            phase     <= PH_IDLE;
            rx_strobe <= 1'b1;
          end
        end
        default:
        begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (phase == PH_DATA && bit_end)
      data_sh <= {rx_sync, data_sh[BYTE_WIDTH-1:1]}; // lsb arrives first.
    if (phase == PH_PARITY && bit_end)
      parity_bit <= rx_sync;
    if (phase == PH_STOP && bit_end)
    begin
      rx_byte <= data_sh;
      rx_err  <= !(^{data_sh, parity_bit}) || !rx_sync;
    end
  end

endmodule

//--- logic/uart_tx_frame.sv
module uart_tx_frame
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [BYTE_WIDTH-1:0] tx_byte,
  input  logic                  tx_start,
  output logic                  tx_done,
  output logic                  tx
);

  frame_phase_t          phase;
  logic [BAUD_CNT_W-1:0] baud_cnt;
  logic [BIT_IDX_W-1:0]  bit_idx;
  logic [BYTE_WIDTH-1:0] data_buf;
  logic                  parity_bit;
  logic                  load;
  logic                  bit_end;

  assign load    = (phase == PH_IDLE) && tx_start;
  assign bit_end = (baud_cnt == BAUD_CNT_W'(BIT_CYCLES - 1));
  assign tx_done = (phase == PH_STOP) && bit_end; // last cycle of the stop bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase    <= PH_IDLE;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else
    begin
      if (phase == PH_IDLE || bit_end)
        baud_cnt <= '0;
      else
        baud_cnt <= baud_cnt + BAUD_CNT_W'(1);

      case (phase)
        PH_IDLE:
        begin
          if (tx_start)
          begin
            phase <= PH_START;
            tx    <= 1'b0;
          end
        end
        PH_START:
        begin
          if (bit_end)
          begin
            phase   <= PH_DATA;
            bit_idx <= '0;
            tx      <= data_buf[0]; // data goes out lsb first.
          end
        end
        PH_DATA:
        begin
          if (bit_end)
          begin
            if (bit_idx == BIT_IDX_W'(BYTE_WIDTH - 1))
            begin
              phase <= PH_PARITY;
              tx    <= parity_bit;
            end
            else
            begin
              bit_idx <= bit_idx + BIT_IDX_W'(1);
              tx      <= data_buf[bit_idx + BIT_IDX_W'(1)];
            end
          end
        end
        PH_PARITY:
        begin
          if (bit_end)
          begin
            phase <= PH_STOP;
            tx    <= 1'b1;
          end
        end
        PH_STOP:
        begin
          if (bit_end)
            phase <= PH_IDLE;
        end
        default:
        begin
          phase <= PH_IDLE;
          tx    <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      data_buf   <= tx_byte;
      parity_bit <= ~^tx_byte; // makes the ones in data and parity an odd count.
    end
  end

endmodule

//--- logic/cmd_sequencer.sv
module cmd_sequencer
  import uart_cmd_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [CMD_WIDTH-1:0]  cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output logic [BYTE_WIDTH-1:0] tx_byte,
  output logic                  tx_start,
  input  logic                  tx_done,
  input  logic [BYTE_WIDTH-1:0] rx_byte,
  input  logic                  rx_strobe,
  input  logic                  rx_err,
  output logic [BYTE_WIDTH-1:0] read_data,
  output logic                  read_rdy,
  output logic                  read_err
);

  seq_state_t               state;
  cmd_op_t                  cmd_op;
  logic [BYTE_WIDTH-1:0]    cmd_lo;
  logic [GAP_CNT_W-1:0]     gap_cnt;
  logic [TIMEOUT_CNT_W-1:0] resp_cnt;
  logic                     cmd_accept;
  logic                     gap_done;
  logic                     resp_expired;

  assign cmd_rdy      = (state == S_IDLE);
  assign cmd_accept   = cmd_vld && cmd_rdy;
  assign gap_done     = (gap_cnt == GAP_CNT_W'(GAP_CYCLES - 1));
  assign resp_expired = (resp_cnt == TIMEOUT_CNT_W'(RESP_TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= S_IDLE;
      tx_start  <= 1'b0;
      gap_cnt   <= '0;
      resp_cnt  <= '0;
      read_rdy  <= 1'b0;
      read_data <= '0;
      read_err  <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        S_IDLE:
        begin
          if (cmd_accept)
          begin
            tx_start <= 1'b1; // high byte goes out the cycle after acceptance.
            state    <= S_SEND_HI;
          end
        end
        S_SEND_HI:
        begin
          gap_cnt  <= '0;
          resp_cnt <= '0;
          if (tx_done)
          begin
            if (cmd_op == OP_WRITE)
              state <= S_GAP;
            else
              state <= S_WAIT_RESP;
          end
        end
        S_GAP:
        begin
          gap_cnt <= gap_cnt + GAP_CNT_W'(1);
          if (gap_done)
          begin
            tx_start <= 1'b1;
            state    <= S_SEND_LO;
          end
        end
        S_SEND_LO:
        begin
          if (tx_done)
            state <= S_IDLE;
        end
        S_WAIT_RESP:
        begin
          resp_cnt <= resp_cnt + TIMEOUT_CNT_W'(1);
          if (rx_strobe)
          begin
            read_data <= rx_byte;
            read_err  <= rx_err;
            read_rdy  <= 1'b1;
            state     <= S_IDLE;
          end
          else if (resp_expired)
          begin
            read_data <= '0; // nothing came back from the device.
            read_err  <= 1'b1;
            read_rdy  <= 1'b1;
            state     <= S_IDLE;
          end
        end
        default:
        begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_accept)
    begin
      cmd_op  <= cmd_op_t'(cmd_in[CMD_WIDTH-1]);
      cmd_lo  <= cmd_in[BYTE_WIDTH-1:0];
      tx_byte <= cmd_in[CMD_WIDTH-1 -: BYTE_WIDTH];
    end
    else if (state == S_GAP && gap_done)
    begin
      tx_byte <= cmd_lo; // low byte is loaded together with its start pulse.
    end
  end

endmodule

//--- logic/uart_cmd_pkg.sv
package uart_cmd_pkg;

  localparam int CMD_WIDTH  = 16;
  localparam int BYTE_WIDTH = 8;

  // serial bit time in clock cycles.
  localparam int BIT_CYCLES      = 434;
  localparam int HALF_BIT_CYCLES = BIT_CYCLES / 2;

  localparam int GAP_CYCLES          = 100;            // idle high between the two write frames.
  localparam int RESP_TIMEOUT_CYCLES = 30 * BIT_CYCLES; // counted from the end of the read frame.

  localparam int BAUD_CNT_W    = $clog2(BIT_CYCLES);
  localparam int BIT_IDX_W     = $clog2(BYTE_WIDTH);
  localparam int GAP_CNT_W     = $clog2(GAP_CYCLES);
  localparam int TIMEOUT_CNT_W = $clog2(RESP_TIMEOUT_CYCLES);

  typedef enum logic [2:0] {
    PH_IDLE,
    PH_START,
    PH_DATA,
    PH_PARITY,
    PH_STOP
  } frame_phase_t;

  // bit 15 of a command word.
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } cmd_op_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_SEND_HI,
    S_GAP,
    S_SEND_LO,
    S_WAIT_RESP
  } seq_state_t;

endpackage
